//--- rtg_video.f
source/rtg_video_pkg.sv
source/rtg_stream_pkg.sv
source/rtg_word_fifo.sv
source/rtg_pixel_decode.sv
source/rtg_palette.sv
source/rtg_video_mix.sv
source/rtg_video_top.sv
verif/rtg_video_clk.sv
verif/rtg_video_assert.sv
verif/rtg_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the RTG video testbench with Verilator, run it, then search the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rtg_video_tb \
  -f rtg_video.f --Mdir obj_dir -o rtg_video_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rtg_video_sim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- source/rtg_palette.sv
/*
  Execute stage. Holds the 256-entry colour lookup table written by the host
  and resolves each pixel to a colour one cycle after decode.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_palette (
  input  wire                               CLK_114,
  input  wire                               rst_n,
  input  wire                               pal_we,         // host write strobe
  input  wire rtg_video_pkg::clut_idx_t     pal_idx,
  input  wire rtg_video_pkg::palette_rgb_t  pal_rgb,
  input  wire                               dec_valid_rtg,
  input  wire                               dec_clut,
  input  wire rtg_video_pkg::clut_idx_t     dec_idx,
  input  wire rtg_video_pkg::colour_t       dec_r,
  input  wire rtg_video_pkg::colour_t       dec_g,
  input  wire rtg_video_pkg::colour_t       dec_b,
  output logic                              lk_rtg,
  output rtg_video_pkg::colour_t            lk_r,
  output rtg_video_pkg::colour_t            lk_g,
  output rtg_video_pkg::colour_t            lk_b
);

  rtg_video_pkg::palette_rgb_t pal_mem [rtg_video_pkg::PALETTE_SIZE];
  rtg_video_pkg::palette_rgb_t pal_entry;

  assign pal_entry = pal_mem[dec_idx];

  // host port, visible to lookups from the next cycle
  always_ff @(posedge CLK_114) begin
    if (pal_we) begin
      pal_mem[pal_idx] <= pal_rgb;
    end
  end

  ////////////////////////////////////////
  // lookup register
  ////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    lk_r <= dec_clut ? pal_entry[23:16] : dec_r;  // table entry or direct colour
    lk_g <= dec_clut ? pal_entry[15:8]  : dec_g;
    lk_b <= dec_clut ? pal_entry[7:0]   : dec_b;
  end

  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      lk_rtg <= 1'b0;
    end else begin
      lk_rtg <= dec_valid_rtg;  // travels with the colour
    end
  end

endmodule

`default_nettype wire

//--- source/rtg_pixel_decode.sv
/*
  Decode stage. Paces pixels at the programmed period, pops words from the
  buffer and turns each pixel into an rgb888 colour or a palette index.
  In clut mode one word feeds two pixels, high byte first.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_pixel_decode (
  input  wire                               CLK_114,
  input  wire                               rst_n,
  input  wire                               rtg_ena,
  input  wire                               rtg_act,        // rtg display window
  input  wire                               rtg_clut,       // 1 = 8-bit indices
  input  wire rtg_stream_pkg::pix_div_t     pixel_div,
  input  wire rtg_video_pkg::pixel_word_t   fifo_word,
  input  wire                               fifo_empty,
  output logic                              fifo_pop,
  output logic                              dec_valid_rtg,
  output logic                              dec_clut,
  output rtg_video_pkg::clut_idx_t          dec_idx,
  output rtg_video_pkg::colour_t            dec_r,
  output rtg_video_pkg::colour_t            dec_g,
  output rtg_video_pkg::colour_t            dec_b
);

  rtg_stream_pkg::pix_div_t   pace_cnt;   // cycles into the current pixel
  logic                       half_sel;   // clut second half pending
  rtg_video_pkg::pixel_word_t word_hold;  // word kept for the low index
  rtg_video_pkg::pixel_word_t cur_word;
  logic                       pix_event;
  logic                       pop_due;
  logic                       under_run;

  ////////////////////////////////////////
  // pacing and pop decision
  ////////////////////////////////////////

  assign pix_event = rtg_act && (pace_cnt == pixel_div);
  assign pop_due   = !rtg_clut || !half_sel;          // rgb565 pops every pixel
  assign under_run = pix_event && pop_due && fifo_empty;
  assign fifo_pop  = pix_event && pop_due && !fifo_empty;
  assign cur_word  = (rtg_clut && half_sel) ? word_hold : fifo_word;

  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      pace_cnt      <= '0;
      half_sel      <= 1'b0;
      dec_valid_rtg <= 1'b0;
      dec_clut      <= 1'b0;
      dec_r         <= '0;
      dec_g         <= '0;
      dec_b         <= '0;
    end else begin
      dec_valid_rtg <= rtg_ena && rtg_act;  // follows the window every cycle
      if (!rtg_act || pix_event) begin
        pace_cnt <= '0;
      end else begin
        pace_cnt <= pace_cnt + 1'b1;
      end
      if (!rtg_act) begin
        half_sel <= 1'b0;  // next line starts on a high byte
        dec_clut <= 1'b0;
        dec_r    <= '0;
        dec_g    <= '0;
        dec_b    <= '0;
      end else if (pix_event) begin
        if (under_run) begin
          dec_clut <= 1'b0;  // black pixel, half flag stays put
          dec_r    <= '0;
          dec_g    <= '0;
          dec_b    <= '0;
        end else begin
          dec_clut <= rtg_clut;
          dec_r    <= {cur_word[15:11], cur_word[15:13]};  // 5 -> 8 bits
          dec_g    <= {cur_word[10:5],  cur_word[10:9]};   // 6 -> 8 bits
          dec_b    <= {cur_word[4:0],   cur_word[4:2]};    // 5 -> 8 bits
          half_sel <= rtg_clut && !half_sel;
        end
      end
    end
  end

  ////////////////////////////////////////
  // index select and word latch
  ////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (pix_event && !under_run) begin
      dec_idx <= half_sel ? cur_word[7:0] : cur_word[15:8];  // high byte first
    end
    if (fifo_pop) begin
      word_hold <= fifo_word;  // low byte used on the next pixel
    end
  end

endmodule

`default_nettype wire

//--- source/rtg_stream_pkg.sv
/*
  Stream definitions for the pixel word buffer and the pixel pacing.
  Buffer depth sets the fetcher's credit count after reset.
*/

`default_nettype none

package rtg_stream_pkg;

  ////////////////////////////////////////
  // word buffer
  ////////////////////////////////////////

  localparam int WORD_FIFO_DEPTH = 8;  // also the initial credit count

  typedef logic [2:0] fifo_ptr_t;      // read / write pointer
  typedef logic [3:0] credit_cnt_t;    // occupancy 0..depth

  ////////////////////////////////////////
  // pixel pacing
  ////////////////////////////////////////

  // pixel period is pixel_div + 1 cycles of CLK_114
  typedef logic [2:0] pix_div_t;

endpackage

`default_nettype wire

//--- source/rtg_video_mix.sv
/*
  Result stage. Lines up the native chipset video with the rtg pipeline,
  picks rtg or native colour, applies the osd tint and registers the pins.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_video_mix (
  input  wire                               CLK_114,
  input  wire                               rst_n,
  input  wire                               lk_rtg,
  input  wire rtg_video_pkg::colour_t       lk_r,
  input  wire rtg_video_pkg::colour_t       lk_g,
  input  wire rtg_video_pkg::colour_t       lk_b,
  input  wire rtg_video_pkg::colour_t       native_r,
  input  wire rtg_video_pkg::colour_t       native_g,
  input  wire rtg_video_pkg::colour_t       native_b,
  input  wire                               native_hs,
  input  wire                               native_vs,
  input  wire                               native_cs,
  input  wire                               osd_window,
  input  wire                               osd_pixel,
  output rtg_video_pkg::colour_t            vga_r,
  output rtg_video_pkg::colour_t            vga_g,
  output rtg_video_pkg::colour_t            vga_b,
  output logic                              vga_hs,
  output logic                              vga_vs,
  output logic                              vga_cs
);

  rtg_video_pkg::colour_t nat_r_d [rtg_video_pkg::NATIVE_DLY];
  rtg_video_pkg::colour_t nat_g_d [rtg_video_pkg::NATIVE_DLY];
  rtg_video_pkg::colour_t nat_b_d [rtg_video_pkg::NATIVE_DLY];
  logic [4:0]             ctl_d   [rtg_video_pkg::NATIVE_DLY];  // hs vs cs win pix
  logic [4:0]             ctl_al;
  rtg_video_pkg::colour_t base_r;
  rtg_video_pkg::colour_t base_g;
  rtg_video_pkg::colour_t base_b;

  // osd tint on top, base colour shifted down under it
  function automatic rtg_video_pkg::colour_t osd_blend(input logic win, input logic [1:0] tint,
                                                       input rtg_video_pkg::colour_t base);
    osd_blend = win ? {tint, base[7:2]} : base;
  endfunction

  ////////////////////////////////////////
  // native alignment
  ////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    nat_r_d[0] <= native_r;
    nat_g_d[0] <= native_g;
    nat_b_d[0] <= native_b;
    for (int i = 1; i < rtg_video_pkg::NATIVE_DLY; i++) begin
      nat_r_d[i] <= nat_r_d[i-1];
      nat_g_d[i] <= nat_g_d[i-1];
      nat_b_d[i] <= nat_b_d[i-1];
    end
  end

  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      for (int i = 0; i < rtg_video_pkg::NATIVE_DLY; i++) begin
        ctl_d[i] <= '0;
      end
    end else begin
      ctl_d[0] <= {native_hs, native_vs, native_cs, osd_window, osd_pixel};
      for (int i = 1; i < rtg_video_pkg::NATIVE_DLY; i++) begin
        ctl_d[i] <= ctl_d[i-1];
      end
    end
  end

  assign ctl_al = ctl_d[rtg_video_pkg::NATIVE_DLY-1];
  assign base_r = lk_rtg ? lk_r : nat_r_d[rtg_video_pkg::NATIVE_DLY-1];  // rtg wins
  assign base_g = lk_rtg ? lk_g : nat_g_d[rtg_video_pkg::NATIVE_DLY-1];
  assign base_b = lk_rtg ? lk_b : nat_b_d[rtg_video_pkg::NATIVE_DLY-1];

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b0;
      vga_vs <= 1'b0;
      vga_cs <= 1'b0;
    end else begin
      vga_r  <= osd_blend(ctl_al[1],
                          ctl_al[0] ? rtg_video_pkg::OSD_ON_R : rtg_video_pkg::OSD_OFF_R, base_r);
      vga_g  <= osd_blend(ctl_al[1],
                          ctl_al[0] ? rtg_video_pkg::OSD_ON_G : rtg_video_pkg::OSD_OFF_G, base_g);
      vga_b  <= osd_blend(ctl_al[1],
                          ctl_al[0] ? rtg_video_pkg::OSD_ON_B : rtg_video_pkg::OSD_OFF_B, base_b);
      vga_hs <= ctl_al[4];
      vga_vs <= ctl_al[3];
      vga_cs <= ctl_al[2];
    end
  end

endmodule

`default_nettype wire

//--- source/rtg_video_pkg.sv
/*
  Pixel format definitions for the RTG video path.
  Colour, word and index types plus the OSD tints and pipeline latency.
*/

`default_nettype none

package rtg_video_pkg;

  ////////////////////////////////////////
  // pixel and colour types
  ////////////////////////////////////////

  typedef logic [7:0]  colour_t;       // one colour channel
  typedef logic [15:0] pixel_word_t;   // fetched word, rgb565 or two indices
  typedef logic [7:0]  clut_idx_t;     // palette index
  typedef logic [23:0] palette_rgb_t;  // red in [23:16], blue in [7:0]

  localparam int PALETTE_SIZE = 256;   // full 8-bit index space

  ////////////////////////////////////////
  // osd tints
  ////////////////////////////////////////

  // tint goes into the top 2 bits of each channel inside the osd window
  localparam logic [1:0] OSD_ON_R  = 2'd3;  // osd pixel set
  localparam logic [1:0] OSD_ON_G  = 2'd3;
  localparam logic [1:0] OSD_ON_B  = 2'd3;
  localparam logic [1:0] OSD_OFF_R = 2'd0;  // osd background, bluish
  localparam logic [1:0] OSD_OFF_G = 2'd0;
  localparam logic [1:0] OSD_OFF_B = 2'd2;

  ////////////////////////////////////////
  // pipeline timing
  ////////////////////////////////////////

  localparam int PIPE_LATENCY = 3;                 // pixel event to vga pins
  localparam int NATIVE_DLY   = PIPE_LATENCY - 1;  // native delay ahead of output reg

endpackage

`default_nettype wire

//--- source/rtg_video_top.sv
/*
  RTG pixel path top level. Word buffer, decode, palette lookup and colour
  mix in a chain; pixel event to vga colour takes three CLK_114 cycles.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_video_top (
  input  wire                               CLK_114,
  input  wire                               rst_n,
  // fetcher side
  input  wire                               word_valid,
  input  wire rtg_video_pkg::pixel_word_t   word_data,
  output logic                              credit_return,
  output rtg_stream_pkg::credit_cnt_t       fill_count,     // buffer occupancy
  // rtg mode control
  input  wire                               rtg_ena,
  input  wire                               rtg_act,
  input  wire                               rtg_clut,
  input  wire rtg_stream_pkg::pix_div_t     pixel_div,
  // host palette port
  input  wire                               pal_we,
  input  wire rtg_video_pkg::clut_idx_t     pal_idx,
  input  wire rtg_video_pkg::palette_rgb_t  pal_rgb,
  // native chipset video and osd
  input  wire rtg_video_pkg::colour_t       native_r,
  input  wire rtg_video_pkg::colour_t       native_g,
  input  wire rtg_video_pkg::colour_t       native_b,
  input  wire                               native_hs,
  input  wire                               native_vs,
  input  wire                               native_cs,
  input  wire                               osd_window,
  input  wire                               osd_pixel,
  // vga pins
  output rtg_video_pkg::colour_t            vga_r,
  output rtg_video_pkg::colour_t            vga_g,
  output rtg_video_pkg::colour_t            vga_b,
  output logic                              vga_hs,
  output logic                              vga_vs,
  output logic                              vga_cs
);

  rtg_video_pkg::pixel_word_t fifo_word;
  logic                       fifo_empty;
  logic                       fifo_pop;
  logic                       dec_valid_rtg;
  logic                       dec_clut;
  rtg_video_pkg::clut_idx_t   dec_idx;
  rtg_video_pkg::colour_t     dec_r, dec_g, dec_b;
  logic                       lk_rtg;
  rtg_video_pkg::colour_t     lk_r, lk_g, lk_b;

  rtg_word_fifo u_fifo (
    .CLK_114(CLK_114), .rst_n(rst_n), .word_valid(word_valid), .word_data(word_data),
    .fifo_pop(fifo_pop), .fifo_word(fifo_word), .fifo_empty(fifo_empty),
    .credit_return(credit_return), .fill_count(fill_count)
  );

  rtg_pixel_decode u_decode (
    .CLK_114(CLK_114), .rst_n(rst_n), .rtg_ena(rtg_ena), .rtg_act(rtg_act),
    .rtg_clut(rtg_clut), .pixel_div(pixel_div), .fifo_word(fifo_word),
    .fifo_empty(fifo_empty), .fifo_pop(fifo_pop), .dec_valid_rtg(dec_valid_rtg),
    .dec_clut(dec_clut), .dec_idx(dec_idx), .dec_r(dec_r), .dec_g(dec_g), .dec_b(dec_b)
  );

  rtg_palette u_palette (
    .CLK_114(CLK_114), .rst_n(rst_n), .pal_we(pal_we), .pal_idx(pal_idx), .pal_rgb(pal_rgb),
    .dec_valid_rtg(dec_valid_rtg), .dec_clut(dec_clut), .dec_idx(dec_idx),
    .dec_r(dec_r), .dec_g(dec_g), .dec_b(dec_b),
    .lk_rtg(lk_rtg), .lk_r(lk_r), .lk_g(lk_g), .lk_b(lk_b)
  );

  rtg_video_mix u_mix (
    .CLK_114(CLK_114), .rst_n(rst_n), .lk_rtg(lk_rtg), .lk_r(lk_r), .lk_g(lk_g), .lk_b(lk_b),
    .native_r(native_r), .native_g(native_g), .native_b(native_b),
    .native_hs(native_hs), .native_vs(native_vs), .native_cs(native_cs),
    .osd_window(osd_window), .osd_pixel(osd_pixel),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
    .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_cs(vga_cs)
  );

endmodule

`default_nettype wire

//--- source/rtg_word_fifo.sv
/*
  Pixel word buffer between the external fetcher and the decode stage.
  Writes are credit limited so there is no ready; each pop returns a credit.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_word_fifo (
  input  wire                               CLK_114,
  input  wire                               rst_n,
  input  wire                               word_valid,     // spends one credit
  input  wire rtg_video_pkg::pixel_word_t   word_data,
  input  wire                               fifo_pop,       // only when not empty
  output rtg_video_pkg::pixel_word_t        fifo_word,      // head word
  output logic                              fifo_empty,
  output logic                              credit_return,  // one cycle after pop
  output rtg_stream_pkg::credit_cnt_t       fill_count
);

  ////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////

  rtg_video_pkg::pixel_word_t  word_mem [rtg_stream_pkg::WORD_FIFO_DEPTH];
  rtg_stream_pkg::fifo_ptr_t   wr_ptr;
  rtg_stream_pkg::fifo_ptr_t   rd_ptr;
  rtg_stream_pkg::credit_cnt_t word_cnt;

  assign fifo_word  = word_mem[rd_ptr];  // head is visible without a read cycle
  assign fifo_empty = (word_cnt == '0);
  assign fill_count = word_cnt;

  // write side, no reset on the data
  always_ff @(posedge CLK_114) begin
    if (word_valid) begin
      word_mem[wr_ptr] <= word_data;
    end
  end

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      word_cnt      <= '0;
      credit_return <= 1'b0;
    end else begin
      if (word_valid) begin
        if (wr_ptr == rtg_stream_pkg::fifo_ptr_t'(rtg_stream_pkg::WORD_FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;  // wrap
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (fifo_pop) begin
        if (rd_ptr == rtg_stream_pkg::fifo_ptr_t'(rtg_stream_pkg::WORD_FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;  // wrap
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // simultaneous write and pop leaves the count alone
      word_cnt <= word_cnt + rtg_stream_pkg::credit_cnt_t'(word_valid)
                           - rtg_stream_pkg::credit_cnt_t'(fifo_pop);
      credit_return <= fifo_pop;  // credit back to the fetcher
    end
  end

endmodule

`default_nettype wire

//--- verif/rtg_video_assert.sv
/*
  Concurrent checks on the pixel word buffer, bound into rtg_word_fifo.
  Covers the credit rule on writes, pops against empty and credit timing.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_video_assert (
  input wire                              CLK_114,
  input wire                              rst_n,
  input wire                              word_valid,
  input wire                              fifo_pop,
  input wire                              fifo_empty,
  input wire                              credit_return,
  input wire rtg_stream_pkg::credit_cnt_t fill_count
);

  // fetcher holds no credit when the buffer is full
  no_write_when_full: assert property (@(posedge CLK_114) disable iff (!rst_n)
    !(word_valid &&
      fill_count == rtg_stream_pkg::credit_cnt_t'(rtg_stream_pkg::WORD_FIFO_DEPTH)))
    else $error("word buffer written while full");

  no_pop_when_empty: assert property (@(posedge CLK_114) disable iff (!rst_n)
    fifo_pop |-> !fifo_empty)
    else $error("word buffer popped while empty");

  credit_after_pop: assert property (@(posedge CLK_114) disable iff (!rst_n)
    fifo_pop |=> credit_return)  // one cycle later
    else $error("no credit returned after a pop");

  credit_only_after_pop: assert property (@(posedge CLK_114) disable iff (!rst_n)
    credit_return |-> $past(fifo_pop))
    else $error("credit returned without a pop");

endmodule

bind rtg_word_fifo rtg_video_assert fifo_checks (
  .CLK_114(CLK_114), .rst_n(rst_n), .word_valid(word_valid), .fifo_pop(fifo_pop),
  .fifo_empty(fifo_empty), .credit_return(credit_return), .fill_count(fill_count)
);

`default_nettype wire

//--- verif/rtg_video_clk.sv
/*
  Clock and reset source for the RTG video testbench.
  40 ns CLK_114 period, rst_n held low over the first 10 rising edges.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_video_clk (
  output logic CLK_114,
  output logic rst_n
);

  initial begin
    CLK_114 = 1'b0;
    forever #20 CLK_114 = ~CLK_114;  // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge CLK_114);  // 10 reset cycles
    #2 rst_n = 1'b1;                 // released like the other stimulus
  end

endmodule

`default_nettype wire

//--- verif/rtg_video_tb.sv
/*
  Testbench for the RTG pixel path. Acts as the credit fetcher and host,
  tracks pacing, buffer and palette, and checks the VGA pins every cycle.
*/

`timescale 1ns/100ps
`default_nettype none

module rtg_video_tb;

  logic                        CLK_114;
  logic                        rst_n;
  logic                        word_valid;
  rtg_video_pkg::pixel_word_t  word_data;
  logic                        credit_return;
  rtg_stream_pkg::credit_cnt_t fill_count;
  logic                        rtg_ena, rtg_act, rtg_clut;
  rtg_stream_pkg::pix_div_t    pixel_div;
  logic                        pal_we;
  rtg_video_pkg::clut_idx_t    pal_idx;
  rtg_video_pkg::palette_rgb_t pal_rgb;
  rtg_video_pkg::colour_t      native_r, native_g, native_b;
  logic                        native_hs, native_vs, native_cs;
  logic                        osd_window, osd_pixel;
  rtg_video_pkg::colour_t      vga_r, vga_g, vga_b;
  logic                        vga_hs, vga_vs, vga_cs;

  integer                      seed = 32'hbf3b600a;
  rtg_stream_pkg::credit_cnt_t credits;     // fetcher side
  int                          words_left;  // words the fetcher still sends
  logic                        feed_en;
  logic                        osd_rand;
  int                          under_runs;

  // reference model state
  rtg_video_pkg::pixel_word_t  word_q [$];  // written, not yet popped
  rtg_video_pkg::palette_rgb_t pal_shadow [rtg_video_pkg::PALETTE_SIZE];
  logic [23:0]                 exp_rgb_q [$];
  logic [2:0]                  exp_sync_q [$];
  rtg_stream_pkg::pix_div_t    m_pace;
  logic                        m_half, m_clut, m_pop_prev;
  rtg_video_pkg::pixel_word_t  m_word, m_latch;
  rtg_video_pkg::clut_idx_t    m_idx;

  rtg_video_clk clk_gen (.CLK_114(CLK_114), .rst_n(rst_n));

  rtg_video_top dut (.*);

  ////////////////////////////////////////
  // error reporting and checks
  ////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_colour(input rtg_video_pkg::colour_t got_r, got_g, got_b,
                              input rtg_video_pkg::colour_t exp_r, exp_g, exp_b);
    if ({got_r, got_g, got_b} !== {exp_r, exp_g, exp_b}) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: vga colour %h %h %h, expected %h %h %h",
                              $time, got_r, got_g, got_b, exp_r, exp_g, exp_b));
    end
  endtask

  task automatic check_sync(input logic got_hs, got_vs, got_cs,
                            input logic exp_hs, exp_vs, exp_cs);
    if ({got_hs, got_vs, got_cs} !== {exp_hs, exp_vs, exp_cs}) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: hs vs cs %b%b%b, expected %b%b%b",
                              $time, got_hs, got_vs, got_cs, exp_hs, exp_vs, exp_cs));
    end
  endtask

  task automatic check_pulse(input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: credit_return %b, expected %b",
                              $time, got, exp));
    end
  endtask

  task automatic check_fill(input rtg_stream_pkg::credit_cnt_t got,
                            input rtg_stream_pkg::credit_cnt_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: fill_count %0d, expected %0d",
                              $time, got, exp));
    end
  endtask

  task automatic check_credit(input rtg_stream_pkg::credit_cnt_t got,
                              input rtg_stream_pkg::credit_cnt_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: fetcher credits %0d, expected %0d",
                              $time, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // reference
  ////////////////////////////////////////

  // colour on the pins for one pixel, osd applied last
  function automatic logic [23:0] expected_rgb(
    input logic                        rtg_on,
    input logic                        clut,
    input rtg_video_pkg::pixel_word_t  word,
    input rtg_video_pkg::palette_rgb_t entry,
    input rtg_video_pkg::colour_t      nat_r,
    input rtg_video_pkg::colour_t      nat_g,
    input rtg_video_pkg::colour_t      nat_b,
    input logic                        win,
    input logic                        dot
  );
    rtg_video_pkg::colour_t r, g, b;
    logic [1:0]             tint_r, tint_g, tint_b;
    if (!rtg_on) begin
      {r, g, b} = {nat_r, nat_g, nat_b};  // native chipset colour
    end else if (clut) begin
      {r, g, b} = entry;
    end else begin
      r = {word[15:11], word[15:13]};  // rgb565, top bits repeated
      g = {word[10:5], word[10:9]};
      b = {word[4:0], word[4:2]};
    end
    tint_r = dot ? rtg_video_pkg::OSD_ON_R : rtg_video_pkg::OSD_OFF_R;
    tint_g = dot ? rtg_video_pkg::OSD_ON_G : rtg_video_pkg::OSD_OFF_G;
    tint_b = dot ? rtg_video_pkg::OSD_ON_B : rtg_video_pkg::OSD_OFF_B;
    if (win) begin
      r = {tint_r, r[7:2]};
      g = {tint_g, g[7:2]};
      b = {tint_b, b[7:2]};
    end
    return {r, g, b};
  endfunction

  // one cycle of the model; bus inputs are the ones the next edge samples
  task automatic model_cycle();
    logic                        due;
    logic                        pop_now;
    logic [23:0]                 exp_rgb;
    logic [2:0]                  exp_sync;
    rtg_video_pkg::palette_rgb_t entry;
    if (exp_rgb_q.size() == 3) begin  // pins show the inputs of 3 edges back
      exp_rgb  = exp_rgb_q.pop_front();
      exp_sync = exp_sync_q.pop_front();
      check_colour(vga_r, vga_g, vga_b, exp_rgb[23:16], exp_rgb[15:8], exp_rgb[7:0]);
      check_sync(vga_hs, vga_vs, vga_cs, exp_sync[2], exp_sync[1], exp_sync[0]);
    end
    check_pulse(credit_return, m_pop_prev);
    check_fill(fill_count, rtg_stream_pkg::credit_cnt_t'(word_q.size()));  // words held now
    pop_now = 1'b0;
    if (!rtg_act) begin
      m_pace = '0;
      m_half = 1'b0;
      m_clut = 1'b0;
      m_word = '0;
    end else if (m_pace == pixel_div) begin  // pixel event
      m_pace = '0;
      due = !rtg_clut || !m_half;
      if (due && word_q.size() == 0) begin
        under_runs++;
        m_clut = 1'b0;  // black
        m_word = '0;
      end else begin
        if (due) begin
          m_latch = word_q.pop_front();
          pop_now = 1'b1;
        end
        m_clut = rtg_clut;
        m_word = m_latch;
        m_idx  = m_half ? m_latch[7:0] : m_latch[15:8];  // high byte first
        m_half = rtg_clut && !m_half;
      end
    end else begin
      m_pace = m_pace + 3'd1;
    end
    if (pal_we) begin
      pal_shadow[pal_idx] = pal_rgb;  // seen by the lookup one edge later
    end
    if (word_valid) begin
      word_q.push_back(word_data);    // poppable from the following edge
    end
    m_pop_prev = pop_now;
    entry = pal_shadow[m_idx];
    exp_rgb_q.push_back(expected_rgb(rtg_ena && rtg_act, m_clut, m_word, entry,
                                     native_r, native_g, native_b, osd_window, osd_pixel));
    exp_sync_q.push_back({native_hs, native_vs, native_cs});
  endtask

  initial begin : compare_proc
    int pre_reset;
    pre_reset  = 0;
    m_pace     = '0;
    m_half     = 1'b0;
    m_clut     = 1'b0;
    m_pop_prev = 1'b0;
    m_word     = '0;
    m_latch    = '0;
    m_idx      = '0;
    under_runs = 0;
    forever begin
      @(negedge CLK_114);  // outputs and inputs both settled here
      if (rst_n === 1'b1) begin
        model_cycle();
      end else if (pre_reset < 40) begin
        pre_reset++;
      end else begin
        stop_on_error("timeout: reset was still asserted after 40 cycles");
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // one clock, fetcher step and random native video
  task tick();
    @(posedge CLK_114);
    #2;
    if (credit_return) begin
      credits = credits + rtg_stream_pkg::credit_cnt_t'(1);
    end
    word_valid = 1'b0;
    if (feed_en && words_left > 0 && credits != '0 && ($random(seed) & 3) != 0) begin
      word_valid = 1'b1;
      word_data  = rtg_video_pkg::pixel_word_t'($random(seed));
      credits    = credits - rtg_stream_pkg::credit_cnt_t'(1);  // spend one credit
      words_left--;
    end
    native_r = rtg_video_pkg::colour_t'($random(seed));
    native_g = rtg_video_pkg::colour_t'($random(seed));
    native_b = rtg_video_pkg::colour_t'($random(seed));
    {native_hs, native_vs, native_cs} = 3'($random(seed));
    {osd_window, osd_pixel} = osd_rand ? 2'($random(seed)) : 2'b00;
  endtask

  task run_line(input int active, input int blank);
    for (int i = 0; i < active; i++) begin
      tick();
      rtg_act = 1'b1;
    end
    for (int i = 0; i < blank; i++) begin
      tick();
      rtg_act = 1'b0;
    end
  endtask

  // lines at random pixel periods until the fetcher and buffer are empty
  task stream_until_drained(input int max_lines);
    int lines;
    lines = 0;
    while ((words_left != 0 || fill_count != '0) && lines < max_lines) begin
      pixel_div = rtg_stream_pkg::pix_div_t'($random(seed));
      run_line(40, 6);
      lines++;
    end
    if (words_left != 0 || fill_count != '0) begin
      stop_on_error("timeout: the pixel stream did not drain");
    end
  endtask

  initial begin : stimulus
    int n;
    word_valid = 1'b0;
    word_data  = '0;
    rtg_ena    = 1'b0;
    rtg_act    = 1'b0;
    rtg_clut   = 1'b0;
    pixel_div  = '0;
    pal_we     = 1'b0;
    pal_idx    = '0;
    pal_rgb    = '0;
    native_r   = '0;
    native_g   = '0;
    native_b   = '0;
    native_hs  = 1'b0;
    native_vs  = 1'b0;
    native_cs  = 1'b0;
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    feed_en    = 1'b0;
    osd_rand   = 1'b0;
    words_left = 0;
    credits    = rtg_stream_pkg::credit_cnt_t'(rtg_stream_pkg::WORD_FIFO_DEPTH);
    n = 0;
    while (rst_n !== 1'b1 && n < 50) begin
      @(posedge CLK_114);
      n++;
    end
    if (rst_n !== 1'b1) begin
      stop_on_error("timeout: reset was never released");
    end

    run_line(0, 20);  // native only, no credits back

    rtg_ena    = 1'b1;  // rgb565 stream
    feed_en    = 1'b1;
    words_left = 40;
    stream_until_drained(40);

    for (int i = 0; i < rtg_video_pkg::PALETTE_SIZE + 16; i++) begin
      tick();
      pal_we  = 1'b1;
      pal_idx = (i < rtg_video_pkg::PALETTE_SIZE) ? rtg_video_pkg::clut_idx_t'(i)
                                                  : rtg_video_pkg::clut_idx_t'($random(seed));
      pal_rgb = rtg_video_pkg::palette_rgb_t'($random(seed));
    end
    tick();
    pal_we     = 1'b0;
    rtg_clut   = 1'b1;  // two indices per word
    words_left = 24;
    stream_until_drained(40);

    rtg_clut  = 1'b0;   // starve the buffer, then resume
    pixel_div = '0;
    feed_en   = 1'b0;
    run_line(30, 4);
    feed_en    = 1'b1;
    words_left = 20;
    stream_until_drained(40);

    osd_rand   = 1'b1;  // osd over rtg and native lines
    words_left = 30;
    for (int i = 0; i < 6; i++) begin
      rtg_ena   = i[0];
      rtg_clut  = 1'($random(seed));
      pixel_div = rtg_stream_pkg::pix_div_t'($random(seed));
      run_line(40, 6);
    end
    rtg_ena = 1'b1;
    stream_until_drained(40);

    osd_rand = 1'b0;
    feed_en  = 1'b0;
    for (int i = 0; i < 4; i++) begin
      tick();  // last credit back
    end
    check_credit(credits, rtg_stream_pkg::credit_cnt_t'(rtg_stream_pkg::WORD_FIFO_DEPTH));
    if (under_runs == 0) begin
      stop_on_error("no under-run happened, the starved line did not run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
